/* Bender.yml */
package:
  name: tenyr_system

sources:
  - verilog/tenyrIsaPkg.sv
  - verilog/tenyrSysPkg.sv
  - verilog/tenyrMem.sv
  - verilog/tenyrRegFile.sv
  - verilog/tenyrExec.sv
  - verilog/tenyrCore.sv
  - verilog/tenyrSystem.sv
  - target: simulation
    files:
      - dv/tenyrCoreSva.sv
      - dv/tenyrSystemTb.sv

/* build.f */
verilog/tenyrIsaPkg.sv
verilog/tenyrSysPkg.sv
verilog/tenyrMem.sv
verilog/tenyrRegFile.sv
verilog/tenyrExec.sv
verilog/tenyrCore.sv
verilog/tenyrSystem.sv
dv/tenyrCoreSva.sv
dv/tenyrSystemTb.sv

/* dv/tenyrCoreSva.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyrCoreSva (
    input logic                            clk,
    input logic                            reset_n,
    input logic [2:0]                      i_phase,
    input logic                            i_halted,
    input logic                            i_retire,
    input logic                            i_wbWe,
    input logic [tenyrIsaPkg::RegBits-1:0] i_wbIndex,
    input logic                            i_memWe
);

    int failCount = 0;   // Read by the testbench at the end

    phaseOneHot: assert property (@(posedge clk) disable iff (!reset_n) $onehot(i_phase))
        else begin
            failCount++;
            $error("Core phase register is not one-hot");
        end

    // Retire only from writeback of a running core
    retireInWb: assert property (@(posedge clk) disable iff (!reset_n)
        i_retire |-> (i_phase[2] && !i_halted))
        else begin
            failCount++;
            $error("Retire outside writeback or while halted");
        end

    wbNotZero: assert property (@(posedge clk) disable iff (!reset_n)
        i_wbWe |-> (i_wbIndex != tenyrIsaPkg::RegZero))
        else begin
            failCount++;
            $error("Register write aimed at register zero");
        end

    memOrReg: assert property (@(posedge clk) disable iff (!reset_n) !(i_memWe && i_wbWe))
        else begin
            failCount++;
            $error("Memory write and register write in the same cycle");
        end

endmodule

bind tenyrCore tenyrCoreSva coreSva (
    .clk       (clk),
    .reset_n   (reset_n),
    .i_phase   (phase),
    .i_halted  (halted),
    .i_retire  (o_retire),
    .i_wbWe    (o_wbWe),
    .i_wbIndex (o_wbIndex),
    .i_memWe   (o_memWe)
);

`default_nettype wire

/* dv/tenyrSystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyrSystemTb;

    localparam int PrologueLen = 30;   // 14 register inits, 16 window stores
    localparam int RandomLen   = 200;
    localparam int ProgLen     = PrologueLen + RandomLen + 1;

    logic        clk;
    logic        reset_n;
    logic        en;
    logic        progWe;
    logic [31:0] progAddr;
    logic [31:0] progData;
    logic        dutHalted;
    logic        dutRetire;
    logic [31:0] dutPc;
    logic        dutWbWe;
    logic [3:0]  dutWbIndex;
    logic [31:0] dutWbValue;
    logic        dutMemWe;
    logic [31:0] dutMemAddr;
    logic [31:0] dutMemData;

    logic [31:0] progWords [ProgLen];
    logic [31:0] modelRegs [16];
    logic [31:0] modelMem [tenyrSysPkg::MemDepth];
    logic [31:0] modelPc;
    int          errorCount;
    int          checkCount;
    int          retireCount;
    int          expectedRetires;
    logic        timedOut;

    always #2 clk = ~clk;

    tenyrSystem tenyrSystem_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_en       (en),
        .i_progWe   (progWe),
        .i_progAddr (progAddr),
        .i_progData (progData),
        .o_halted   (dutHalted),
        .o_retire   (dutRetire),
        .o_pc       (dutPc),
        .o_wbWe     (dutWbWe),
        .o_wbIndex  (dutWbIndex),
        .o_wbValue  (dutWbValue),
        .o_memWe    (dutMemWe),
        .o_memAddr  (dutMemAddr),
        .o_memData  (dutMemData)
    );

    function automatic logic [31:0] encode(input logic t, input logic [1:0] d,
                                           input logic [3:0] z, input logic [3:0] x,
                                           input logic [3:0] y, input logic [3:0] op,
                                           input logic [11:0] imm);
        logic [31:0] word;
        word = '0;
        word[tenyrIsaPkg::TypeBit] = t;
        word[tenyrIsaPkg::DerefLsb +: 2] = d;
        word[tenyrIsaPkg::ZLsb +: 4] = z;
        word[tenyrIsaPkg::XLsb +: 4] = x;
        word[tenyrIsaPkg::YLsb +: 4] = y;
        word[tenyrIsaPkg::OpLsb +: 4] = op;
        word[tenyrIsaPkg::ImmLsb +: 12] = imm;
        return word;
    endfunction

    // Reference operator table
    function automatic logic [31:0] applyOp(input logic [3:0] op, input logic [31:0] x,
                                            input logic [31:0] o);
        case (op)
            tenyrIsaPkg::OpOr:   return x | o;
            tenyrIsaPkg::OpAnd:  return x & o;
            tenyrIsaPkg::OpAdd:  return x + o;
            tenyrIsaPkg::OpMul:  return x * o;
            tenyrIsaPkg::OpShl:  return (o > 32'd31) ? 32'd0 : x << o[4:0];
            tenyrIsaPkg::OpLt:   return ($signed(x) < $signed(o)) ? 32'hffff_ffff : 32'd0;
            tenyrIsaPkg::OpEq:   return (x == o) ? 32'hffff_ffff : 32'd0;
            tenyrIsaPkg::OpGt:   return ($signed(x) > $signed(o)) ? 32'hffff_ffff : 32'd0;
            tenyrIsaPkg::OpAndn: return x & ~o;
            tenyrIsaPkg::OpXor:  return x ^ o;
            tenyrIsaPkg::OpSub:  return x - o;
            tenyrIsaPkg::OpXnor: return ~(x ^ o);
            tenyrIsaPkg::OpShr:  return (o > 32'd31) ? 32'd0 : x >> o[4:0];
            tenyrIsaPkg::OpNe:   return (x != o) ? 32'hffff_ffff : 32'd0;
            default:             return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] regValue(input logic [3:0] index);
        if (index == tenyrIsaPkg::RegZero) return 32'd0;
        if (index == tenyrIsaPkg::RegPc) return modelPc + 32'd1;
        return modelRegs[index];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic buildProgram();
        logic        t;
        logic [1:0]  d;
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        logic [3:0]  op;
        logic [11:0] imm;
        int          pc;
        for (int i = 0; i < 14; i++) begin
            progWords[i] = encode(1'b0, tenyrIsaPkg::DerefNone, 4'(i + 1), 4'd0, 4'd0,
                                  tenyrIsaPkg::OpOr, 12'($urandom));
        end
        for (int k = 0; k < 16; k++) begin   // Defined words for loads to find
            progWords[14 + k] = encode(1'b0, tenyrIsaPkg::DerefStoreFromZ,
                                       4'(1 + $urandom % 14), 4'd0, 4'd0,
                                       tenyrIsaPkg::OpOr, 12'(k));
        end
        for (int i = PrologueLen; i < ProgLen - 1; i++) begin
            t = 1'($urandom);
            d = 2'($urandom);
            z = 4'($urandom);
            x = 4'($urandom);
            y = 4'($urandom);
            op = 4'($urandom);
            imm = 12'($urandom);
            if (op == tenyrIsaPkg::OpRsvdA || op == tenyrIsaPkg::OpRsvdB) op = op - 4'd1;
            if (z == tenyrIsaPkg::RegPc && d != tenyrIsaPkg::DerefNone) z = 4'd14;
            if ((op == tenyrIsaPkg::OpShl || op == tenyrIsaPkg::OpShr) && t) begin
                imm = 12'($urandom % 40);   // Shift counts around the word size
            end
            if (d == tenyrIsaPkg::DerefLoad
                || (d == tenyrIsaPkg::DerefStoreFromZ && $urandom % 2 == 0)) begin
                t = 1'b0;   // Address lands in the stored window
                x = tenyrIsaPkg::RegZero;
                y = tenyrIsaPkg::RegZero;
                op = tenyrIsaPkg::OpOr;
                imm = 12'($urandom % 16);
            end else if (z == tenyrIsaPkg::RegPc) begin
                t = 1'b0;   // Short forward jump that stays inside the program
                x = tenyrIsaPkg::RegPc;
                y = tenyrIsaPkg::RegZero;
                op = tenyrIsaPkg::OpOr;
                imm = 12'($urandom % 4);
                if (i + 1 + imm > ProgLen - 1) imm = 12'(ProgLen - 2 - i);
            end
            progWords[i] = encode(t, d, z, x, y, op, imm);
        end
        progWords[ProgLen - 1] = tenyrIsaPkg::IllegalInsn;
        // Count the straight-line path through the jumps
        pc = 0;
        expectedRetires = 0;
        while (progWords[pc] != tenyrIsaPkg::IllegalInsn) begin
            expectedRetires++;
            if (progWords[pc][tenyrIsaPkg::ZLsb +: 4] == tenyrIsaPkg::RegPc
                && progWords[pc][tenyrIsaPkg::DerefLsb +: 2] == tenyrIsaPkg::DerefNone) begin
                pc = pc + 1 + int'(progWords[pc][tenyrIsaPkg::ImmLsb +: 12]);
            end else begin
                pc++;
            end
        end
    endtask

    task automatic checkRetire();
        logic [31:0] insn;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [31:0] immExt;
        logic [31:0] opO;
        logic [31:0] opA;
        logic [31:0] rhs;
        logic [31:0] value;
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  d;
        logic [3:0]  idxZ;
        logic        wbWe;
        logic        memWe;
        retireCount++;
        if (modelPc >= ProgLen) begin
            errorCount++;
            $display("Retire at %0t from address %0d outside the program", $time, modelPc);
        end else begin
            insn = progWords[modelPc];
            d = insn[tenyrIsaPkg::DerefLsb +: 2];
            idxZ = insn[tenyrIsaPkg::ZLsb +: 4];
            x = regValue(insn[tenyrIsaPkg::XLsb +: 4]);
            y = regValue(insn[tenyrIsaPkg::YLsb +: 4]);
            z = regValue(idxZ);
            immExt = {{20{insn[tenyrIsaPkg::ImmLsb + 11]}}, insn[tenyrIsaPkg::ImmLsb +: 12]};
            opO = insn[tenyrIsaPkg::TypeBit] ? immExt : y;
            opA = insn[tenyrIsaPkg::TypeBit] ? y : immExt;
            rhs = applyOp(insn[tenyrIsaPkg::OpLsb +: 4], x, opO) + opA;
            value = (d == tenyrIsaPkg::DerefLoad) ? modelMem[rhs % tenyrSysPkg::MemDepth] : rhs;
            memWe = d[1];   // Both store modes
            wbWe = !memWe && idxZ != tenyrIsaPkg::RegZero;
            addr = (d == tenyrIsaPkg::DerefStoreAtZ) ? z
                 : (d == tenyrIsaPkg::DerefNone) ? 32'd0 : rhs;
            data = (d == tenyrIsaPkg::DerefStoreAtZ) ? rhs
                 : (d == tenyrIsaPkg::DerefStoreFromZ) ? z : 32'd0;
            checkValue("o_pc", modelPc, dutPc);
            checkValue("o_wbWe", 32'(wbWe), 32'(dutWbWe));
            checkValue("o_wbIndex", 32'(idxZ), 32'(dutWbIndex));
            checkValue("o_wbValue", value, dutWbValue);
            checkValue("o_memWe", 32'(memWe), 32'(dutMemWe));
            checkValue("o_memAddr", addr, dutMemAddr);
            checkValue("o_memData", data, dutMemData);
            if (memWe) modelMem[addr % tenyrSysPkg::MemDepth] = data;
            if (wbWe && idxZ != tenyrIsaPkg::RegPc) modelRegs[idxZ] = value;
            modelPc = (wbWe && idxZ == tenyrIsaPkg::RegPc) ? value : modelPc + 32'd1;
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (reset_n && dutRetire) checkRetire();
    end

    task automatic applyReset();
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        en = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < ProgLen; i++) begin
            @(posedge clk);
            #1;
            progWe = 1'b1;
            progAddr = 32'(i);
            progData = progWords[i];
        end
        @(posedge clk);
        #1;
        progWe = 1'b0;
    endtask

    // Core must freeze while disabled
    task automatic holdEnable();
        int savedRetires;
        int len;
        savedRetires = retireCount;
        len = 4 + $urandom % 13;
        en = 1'b0;
        repeat (len) begin
            @(posedge clk);
            #1;
            checkValue("o_pc during hold", modelPc, dutPc);
        end
        checkValue("retires during hold", 32'(savedRetires), 32'(retireCount));
        en = 1'b1;
    endtask

    task automatic runProgram();
        int   limit;
        int   cycles;
        int   stallAt;
        int   held;
        logic stalled;
        modelPc = tenyrSysPkg::ResetVector;
        retireCount = 0;
        limit = 3 * (expectedRetires + 10);
        cycles = 0;
        stalled = 1'b0;
        stallAt = 20 + $urandom % (expectedRetires - 40);
        en = 1'b1;
        while (!dutHalted && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (!stalled && retireCount >= stallAt) begin
                holdEnable();
                stalled = 1'b1;
            end
        end
        if (!dutHalted) begin
            timedOut = 1'b1;
            errorCount++;
            $display("Timeout: core did not halt within %0d enabled cycles", limit);
        end else begin
            checkValue("o_pc at halt", modelPc, dutPc);
            checkValue("retire count", 32'(expectedRetires), 32'(retireCount));
            held = retireCount;
            repeat (4) @(posedge clk);
            #1;
            checkValue("retires after halt", 32'(held), 32'(retireCount));
            checkValue("o_halted", 32'd1, 32'(dutHalted));
        end
        en = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        en = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        errorCount = 0;
        checkCount = 0;
        retireCount = 0;
        timedOut = 1'b0;
        void'($urandom(32'h6bd8));
        buildProgram();
        applyReset();
        loadProgram();
        runProgram();
        if (!timedOut) begin
            applyReset();   // Second pass from the reset vector
            runProgram();
        end
        errorCount += tenyrSystem_inst.tenyrCore_inst.coreSva.failCount;
        $display("Checks: %0d, retires expected per run: %0d, errors: %0d",
                 checkCount, expectedRetires, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/tenyrCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyrCore (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               i_en,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_insnData,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_memRdata,
    output logic [tenyrSysPkg::WordBits-1:0]   o_insnAddr,
    output logic [tenyrSysPkg::WordBits-1:0]   o_memAddr,
    output logic [tenyrSysPkg::WordBits-1:0]   o_memData,
    output logic                               o_memWe,
    output logic                               o_halted,
    output logic                               o_retire,
    output logic                               o_wbWe,
    output logic [tenyrIsaPkg::RegBits-1:0]    o_wbIndex,
    output logic [tenyrSysPkg::WordBits-1:0]   o_wbValue,
    output logic [tenyrSysPkg::WordBits-1:0]   o_pc
);

    // Decoded fields
    logic                                insnType;
    logic [tenyrIsaPkg::DerefBits-1:0]   deref;
    logic [tenyrIsaPkg::RegBits-1:0]     idxZ;
    logic [tenyrIsaPkg::RegBits-1:0]     idxX;
    logic [tenyrIsaPkg::RegBits-1:0]     idxY;
    logic [tenyrIsaPkg::OpBits-1:0]      op;
    logic [tenyrIsaPkg::ImmBits-1:0]     imm;
    logic                                illegal;

    logic [2:0]                          phase;     // One-hot, bit 0 is decode
    logic                                inDecode;
    logic                                inExec;
    logic                                inWb;
    logic                                halted;
    logic [tenyrSysPkg::WordBits-1:0]    pc;

    logic [tenyrSysPkg::WordBits-1:0]    valueX;
    logic [tenyrSysPkg::WordBits-1:0]    valueY;
    logic [tenyrSysPkg::WordBits-1:0]    valueZ;
    logic [tenyrSysPkg::WordBits-1:0]    rhs;
    logic                                regWrite;
    logic                                jumping;
    logic                                isStore;

    // Word stays stable for all three phases since pc only moves after writeback
    assign insnType = i_insnData[tenyrIsaPkg::TypeBit];
    assign deref    = i_insnData[tenyrIsaPkg::DerefLsb +: tenyrIsaPkg::DerefBits];
    assign idxZ     = i_insnData[tenyrIsaPkg::ZLsb +: tenyrIsaPkg::RegBits];
    assign idxX     = i_insnData[tenyrIsaPkg::XLsb +: tenyrIsaPkg::RegBits];
    assign idxY     = i_insnData[tenyrIsaPkg::YLsb +: tenyrIsaPkg::RegBits];
    assign op       = i_insnData[tenyrIsaPkg::OpLsb +: tenyrIsaPkg::OpBits];
    assign imm      = i_insnData[tenyrIsaPkg::ImmLsb +: tenyrIsaPkg::ImmBits];

    assign illegal = (i_insnData == tenyrIsaPkg::IllegalInsn)
                   || (op == tenyrIsaPkg::OpRsvdA)
                   || (op == tenyrIsaPkg::OpRsvdB);

    assign inDecode = phase[0];
    assign inExec   = phase[1];
    assign inWb     = phase[2];

    // An illegal word parks the sequencer in decode for good
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase  <= 3'b001;
            halted <= 1'b0;
            pc     <= tenyrSysPkg::ResetVector;
        end else if (i_en && !halted) begin
            if (inDecode && illegal) begin
                halted <= 1'b1;
            end else begin
                phase <= {phase[1:0], phase[2]};
            end
            if (inWb) begin
                pc <= jumping ? o_wbValue : pc + 1'b1;
            end
        end
    end

    // Stores never touch Z
    assign isStore  = (deref == tenyrIsaPkg::DerefStoreAtZ)
                    || (deref == tenyrIsaPkg::DerefStoreFromZ);
    assign regWrite = !isStore && (idxZ != tenyrIsaPkg::RegZero);
    assign jumping  = regWrite && (idxZ == tenyrIsaPkg::RegPc);

    assign o_wbValue = (deref == tenyrIsaPkg::DerefLoad) ? i_memRdata : rhs;

    // Data side addressing per mode
    always_comb begin
        o_memAddr = '0;
        o_memData = '0;
        case (deref)
            tenyrIsaPkg::DerefLoad: begin
                o_memAddr = rhs;
            end
            tenyrIsaPkg::DerefStoreAtZ: begin
                o_memAddr = valueZ;
                o_memData = rhs;
            end
            tenyrIsaPkg::DerefStoreFromZ: begin
                o_memAddr = rhs;
                o_memData = valueZ;
            end
            default: ;   // Plain register write
        endcase
    end

    assign o_retire   = inWb && i_en && !halted;
    assign o_wbWe     = o_retire && regWrite;
    assign o_memWe    = o_retire && isStore;
    assign o_wbIndex  = idxZ;
    assign o_insnAddr = pc;
    assign o_pc       = pc;
    assign o_halted   = halted;

    tenyrRegFile tenyrRegFile_inst (
        .clk       (clk),
        .i_we      (o_wbWe),
        .i_wIndex  (idxZ),
        .i_rIndexX (idxX),
        .i_rIndexY (idxY),
        .i_rIndexZ (idxZ),
        .i_wData   (o_wbValue),
        .i_pc      (pc),
        .o_x       (valueX),
        .o_y       (valueY),
        .o_z       (valueZ)
    );

    // Register reads settle in decode, the result is latched at end of execute
    tenyrExec tenyrExec_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .i_en    (i_en && inExec),
        .i_type  (insnType),
        .i_op    (op),
        .i_x     (valueX),
        .i_y     (valueY),
        .i_imm   (imm),
        .o_rhs   (rhs)
    );

endmodule

`default_nettype wire

/* verilog/tenyrExec.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyrExec (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               i_en,
    input  logic                               i_type,
    input  logic [tenyrIsaPkg::OpBits-1:0]     i_op,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_x,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_y,
    input  logic [tenyrIsaPkg::ImmBits-1:0]    i_imm,
    output logic [tenyrSysPkg::WordBits-1:0]   o_rhs
);

    logic [tenyrSysPkg::WordBits-1:0] immExt;
    logic [tenyrSysPkg::WordBits-1:0] opO;
    logic [tenyrSysPkg::WordBits-1:0] opA;
    logic [tenyrSysPkg::WordBits-1:0] opResult;
    logic [tenyrSysPkg::WordBits-1:0] nextRhs;
    logic                             opValid;

    assign immExt = {{(tenyrSysPkg::WordBits - tenyrIsaPkg::ImmBits){i_imm[11]}}, i_imm};

    // Type 0 is X op Y + I, type 1 is X op I + Y
    assign opO = i_type ? immExt : i_y;
    assign opA = i_type ? i_y : immExt;

    always_comb begin
        opValid = 1'b1;
        case (i_op)
            tenyrIsaPkg::OpOr:   opResult = i_x | opO;
            tenyrIsaPkg::OpAnd:  opResult = i_x & opO;
            tenyrIsaPkg::OpAdd:  opResult = i_x + opO;
            tenyrIsaPkg::OpMul:  opResult = i_x * opO;     // Low word only
            tenyrIsaPkg::OpShl:  opResult = i_x << opO;    // Zero once O reaches 32
            tenyrIsaPkg::OpLt:
                opResult = {tenyrSysPkg::WordBits{$signed(i_x) < $signed(opO)}};
            tenyrIsaPkg::OpEq:   opResult = {tenyrSysPkg::WordBits{i_x == opO}};
            tenyrIsaPkg::OpGt:
                opResult = {tenyrSysPkg::WordBits{$signed(i_x) > $signed(opO)}};
            tenyrIsaPkg::OpAndn: opResult = i_x & ~opO;
            tenyrIsaPkg::OpXor:  opResult = i_x ^ opO;
            tenyrIsaPkg::OpSub:  opResult = i_x - opO;
            tenyrIsaPkg::OpXnor: opResult = i_x ^~ opO;
            tenyrIsaPkg::OpShr:  opResult = i_x >> opO;    // Logical
            tenyrIsaPkg::OpNe:   opResult = {tenyrSysPkg::WordBits{i_x != opO}};
            default: begin
                // Reserved encodings halt the core
                opResult = '0;
                opValid  = 1'b0;
            end
        endcase
    end

    assign nextRhs = opValid ? opResult + opA : '0;

    // Captured at the end of the execute phase
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            o_rhs <= '0;
        end else if (i_en) begin
            o_rhs <= nextRhs;
        end
    end

endmodule

`default_nettype wire

/* verilog/tenyrIsaPkg.sv */
`default_nettype none

package tenyrIsaPkg;

    // Field positions within an instruction word
    localparam int TypeBit  = 30;   // Selects operand order
    localparam int DerefLsb = 28;
    localparam int ZLsb     = 24;
    localparam int XLsb     = 20;
    localparam int YLsb     = 16;
    localparam int OpLsb    = 12;
    localparam int ImmLsb   = 0;

    // Field widths
    localparam int OpBits    = 4;
    localparam int RegBits   = 4;
    localparam int ImmBits   = 12;
    localparam int DerefBits = 2;

    // Operators applied as (X op O) + A
    localparam logic [OpBits-1:0] OpOr    = 4'b0000;
    localparam logic [OpBits-1:0] OpAnd   = 4'b0001;
    localparam logic [OpBits-1:0] OpAdd   = 4'b0010;
    localparam logic [OpBits-1:0] OpMul   = 4'b0011;
    localparam logic [OpBits-1:0] OpRsvdA = 4'b0100; // Halts the core
    localparam logic [OpBits-1:0] OpShl   = 4'b0101;
    localparam logic [OpBits-1:0] OpLt    = 4'b0110;
    localparam logic [OpBits-1:0] OpEq    = 4'b0111;
    localparam logic [OpBits-1:0] OpGt    = 4'b1000;
    localparam logic [OpBits-1:0] OpAndn  = 4'b1001;
    localparam logic [OpBits-1:0] OpXor   = 4'b1010;
    localparam logic [OpBits-1:0] OpSub   = 4'b1011;
    localparam logic [OpBits-1:0] OpXnor  = 4'b1100;
    localparam logic [OpBits-1:0] OpShr   = 4'b1101;
    localparam logic [OpBits-1:0] OpNe    = 4'b1110;
    localparam logic [OpBits-1:0] OpRsvdB = 4'b1111; // Halts the core

    // Dereference modes
    localparam logic [DerefBits-1:0] DerefNone       = 2'b00; // Z gets rhs
    localparam logic [DerefBits-1:0] DerefLoad       = 2'b01; // Z gets word at rhs
    localparam logic [DerefBits-1:0] DerefStoreAtZ   = 2'b10; // Word at Z gets rhs
    localparam logic [DerefBits-1:0] DerefStoreFromZ = 2'b11; // Word at rhs gets Z

    // Registers with fixed meaning
    localparam logic [RegBits-1:0] RegZero = 4'd0;
    localparam logic [RegBits-1:0] RegPc   = 4'd15;

    // All ones word always stops the core
    localparam logic [31:0] IllegalInsn = 32'hffff_ffff;

endpackage

`default_nettype wire

/* verilog/tenyrMem.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyrMem (
    input  logic                               clk,
    input  logic                               i_we,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_wAddr,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_rAddr,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_wData,
    output logic [tenyrSysPkg::WordBits-1:0]   o_rData
);

    logic [tenyrSysPkg::WordBits-1:0] words [tenyrSysPkg::MemDepth];
    logic [tenyrSysPkg::AddrBits-1:0] wIndex;
    logic [tenyrSysPkg::AddrBits-1:0] rIndex;

    // Addresses wrap at the memory depth
    assign wIndex = i_wAddr[tenyrSysPkg::AddrBits-1:0];
    assign rIndex = i_rAddr[tenyrSysPkg::AddrBits-1:0];

    always_ff @(posedge clk) begin
        if (i_we) begin
            words[wIndex] <= i_wData;
        end
    end

    assign o_rData = words[rIndex];   // Same-cycle read

endmodule

`default_nettype wire

/* verilog/tenyrRegFile.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyrRegFile (
    input  logic                               clk,
    input  logic                               i_we,
    input  logic [tenyrIsaPkg::RegBits-1:0]    i_wIndex,
    input  logic [tenyrIsaPkg::RegBits-1:0]    i_rIndexX,
    input  logic [tenyrIsaPkg::RegBits-1:0]    i_rIndexY,
    input  logic [tenyrIsaPkg::RegBits-1:0]    i_rIndexZ,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_wData,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_pc,
    output logic [tenyrSysPkg::WordBits-1:0]   o_x,
    output logic [tenyrSysPkg::WordBits-1:0]   o_y,
    output logic [tenyrSysPkg::WordBits-1:0]   o_z
);

    logic [tenyrSysPkg::WordBits-1:0] regs [1:14];  // Only the general registers

    // Zero and PC are synthesized on read
    function automatic logic [tenyrSysPkg::WordBits-1:0] readReg(
        input logic [tenyrIsaPkg::RegBits-1:0] index
    );
        logic [tenyrSysPkg::WordBits-1:0] value;
        if (index == tenyrIsaPkg::RegZero) begin
            value = '0;
        end else if (index == tenyrIsaPkg::RegPc) begin
            value = i_pc + 1'b1;
        end else begin
            value = regs[index];
        end
        return value;
    endfunction

    always_comb begin
        o_x = readReg(i_rIndexX);
        o_y = readReg(i_rIndexY);
        o_z = readReg(i_rIndexZ);
    end

    // PC writes are handled by the core as jumps
    always_ff @(posedge clk) begin
        if (i_we && i_wIndex != tenyrIsaPkg::RegZero && i_wIndex != tenyrIsaPkg::RegPc) begin
            regs[i_wIndex] <= i_wData;
        end
    end

endmodule

`default_nettype wire

/* verilog/tenyrSysPkg.sv */
`default_nettype none

package tenyrSysPkg;

    // Datapath word
    localparam int WordBits = 32;

    // Words per memory instance
    localparam int MemDepth = 1024;

    // Index width into a memory
    // Upper address bits are ignored so addresses wrap
    localparam int AddrBits = $clog2(MemDepth);

    // First instruction fetched after reset
    localparam logic [WordBits-1:0] ResetVector = 32'h0000_0000;

endpackage

`default_nettype wire

/* verilog/tenyrSystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tenyrSystem (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               i_en,
    input  logic                               i_progWe,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_progAddr,
    input  logic [tenyrSysPkg::WordBits-1:0]   i_progData,
    output logic                               o_halted,
    output logic                               o_retire,
    output logic [tenyrSysPkg::WordBits-1:0]   o_pc,
    output logic                               o_wbWe,
    output logic [tenyrIsaPkg::RegBits-1:0]    o_wbIndex,
    output logic [tenyrSysPkg::WordBits-1:0]   o_wbValue,
    output logic                               o_memWe,
    output logic [tenyrSysPkg::WordBits-1:0]   o_memAddr,
    output logic [tenyrSysPkg::WordBits-1:0]   o_memData
);

    logic [tenyrSysPkg::WordBits-1:0] insnAddr;
    logic [tenyrSysPkg::WordBits-1:0] insnData;
    logic [tenyrSysPkg::WordBits-1:0] memRdata;

    tenyrCore tenyrCore_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_en       (i_en),
        .i_insnData (insnData),
        .i_memRdata (memRdata),
        .o_insnAddr (insnAddr),
        .o_memAddr  (o_memAddr),
        .o_memData  (o_memData),
        .o_memWe    (o_memWe),
        .o_halted   (o_halted),
        .o_retire   (o_retire),
        .o_wbWe     (o_wbWe),
        .o_wbIndex  (o_wbIndex),
        .o_wbValue  (o_wbValue),
        .o_pc       (o_pc)
    );

    // Program store, written only from the load port
    tenyrMem insnMem (
        .clk     (clk),
        .i_we    (i_progWe),
        .i_wAddr (i_progAddr),
        .i_rAddr (insnAddr),
        .i_wData (i_progData),
        .o_rData (insnData)
    );

    // Loads and stores share one address
    tenyrMem dataMem (
        .clk     (clk),
        .i_we    (o_memWe),
        .i_wAddr (o_memAddr),
        .i_rAddr (o_memAddr),
        .i_wData (o_memData),
        .o_rData (memRdata)
    );

endmodule

`default_nettype wire
